/* fp_misc_pkg.sv */
// Widths, operation codes, floating-point word union and packet structs
package fp_misc_pkg;

  ////////////////////
  // Single-precision layout
  localparam int FLEN         = 32;
  localparam int EXPO_WIDTH   = 8;
  localparam int FRAC_WIDTH   = 23;
  localparam int CLASS_MASK_W = 10;

  // Returned by min/max when both inputs are NaN
  localparam logic [FLEN-1:0] CANONICAL_NAN = 32'h7FC0_0000;

  ////////////////////
  // Operation codes
  typedef enum logic [3:0] {
    FSGNJ,
    FSGNJN,
    FSGNJX,
    FMIN,
    FMAX,
    FEQ,
    FLT,
    FLE,
    FCLASS
  } fp_op_e;

  ////////////////////
  // Floating-point word as raw bits or as fields
  typedef struct packed {
    logic                  sign;
    logic [EXPO_WIDTH-1:0] exponent;
    logic [FRAC_WIDTH-1:0] fraction;
  } fp_fields_t;

  typedef union packed {
    logic [FLEN-1:0] bits;
    fp_fields_t      f;
  } fp_word_u;

  // Special case flags of one operand
  typedef struct packed {
    logic is_inf;
    logic is_snan;
    logic is_qnan;
    logic is_zero;
    logic is_subnormal;
  } fp_class_t;

  ////////////////////
  // Packets
  typedef struct packed {
    fp_op_e   op;
    fp_word_u rs1;
    fp_word_u rs2;
  } fp_request_t;

  typedef struct packed {
    fp_request_t req;
    fp_class_t   cls1;
    fp_class_t   cls2;
    logic        mag_lt;  // |rs1| < |rs2| with sign ignored
  } fp_classified_t;

  typedef struct packed {
    logic [FLEN-1:0] value;
    logic            invalid;
  } fp_result_t;

endpackage

/* fp_operand_classifier.sv */
// Request acceptance by req/ack, operand classification and magnitude order
`timescale 1ns/1ps

module fp_operand_classifier (
  input  logic                        clk,
  input  logic                        i_arst_n,
  input  logic                        i_req,
  input  fp_misc_pkg::fp_request_t    i_request,
  input  logic                        i_full,
  output logic                        o_ack,
  output logic                        o_push,
  output fp_misc_pkg::fp_classified_t o_entry
);
  import fp_misc_pkg::*;

  logic        ack_q;
  logic        push_q;
  logic        capture;
  fp_request_t req_q;
  fp_class_t   cls1;
  fp_class_t   cls2;
  logic        mag_lt;

  // Decode the special cases of one operand from its fields
  function automatic fp_class_t classify(input fp_word_u w);
    fp_class_t c;
    logic      exp_ones;
    logic      exp_zero;
    logic      frac_zero;
    exp_ones       = &w.f.exponent;
    exp_zero       = ~|w.f.exponent;
    frac_zero      = ~|w.f.fraction;
    c.is_inf       = exp_ones & frac_zero;
    // Top fraction bit picks quiet over signalling
    c.is_snan      = exp_ones & ~frac_zero & ~w.f.fraction[FRAC_WIDTH-1];
    c.is_qnan      = exp_ones & w.f.fraction[FRAC_WIDTH-1];
    c.is_zero      = exp_zero & frac_zero;
    c.is_subnormal = exp_zero & ~frac_zero;
    return c;
  endfunction

  ////////////////////
  // Four-phase acceptance
  assign capture = i_req & ~ack_q & ~i_full;

  always_ff @(posedge clk or negedge i_arst_n) begin
    if (!i_arst_n) begin
      ack_q  <= 1'b0;
      push_q <= 1'b0;
    end else begin
      push_q <= capture;
      if (capture) begin
        ack_q <= 1'b1;
      end else if (ack_q && !i_req) begin
        ack_q <= 1'b0;
      end
    end
  end

  // Captured request
  always_ff @(posedge clk) begin
    if (capture) begin
      req_q <= i_request;
    end
  end

  ////////////////////
  // Classification on the captured request
  assign cls1 = classify(req_q.rs1);
  assign cls2 = classify(req_q.rs2);

  // Magnitude order on exponent and fraction as in the swap decision
  assign mag_lt = {req_q.rs1.f.exponent, req_q.rs1.f.fraction} <
                  {req_q.rs2.f.exponent, req_q.rs2.f.fraction};

  assign o_ack          = ack_q;
  assign o_push         = push_q;
  assign o_entry.req    = req_q;
  assign o_entry.cls1   = cls1;
  assign o_entry.cls2   = cls2;
  assign o_entry.mag_lt = mag_lt;

endmodule

/* fp_request_fifo.sv */
// Circular FIFO of classified requests
`timescale 1ns/1ps

module fp_request_fifo #(
  parameter int DEPTH = 4
) (
  input  logic                        clk,
  input  logic                        i_arst_n,
  input  logic                        i_push,
  input  fp_misc_pkg::fp_classified_t i_entry,
  input  logic                        i_pop,
  output logic                        o_full,
  output logic                        o_empty,
  output fp_misc_pkg::fp_classified_t o_head
);
  import fp_misc_pkg::*;

  localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int CNT_W = $clog2(DEPTH + 1);

  fp_classified_t   mem [DEPTH];
  logic [PTR_W-1:0] wr_ptr_q;
  logic [PTR_W-1:0] rd_ptr_q;
  logic [CNT_W-1:0] count_q;
  logic             do_push;
  logic             do_pop;

  assign do_push = i_push & (count_q != CNT_W'(DEPTH));
  assign do_pop  = i_pop & ~o_empty;

  // Full also counts a push in progress
  assign o_full  = (count_q == CNT_W'(DEPTH)) |
                   (i_push & (count_q == CNT_W'(DEPTH - 1)));
  assign o_empty = (count_q == '0);
  assign o_head  = mem[rd_ptr_q];

  always_ff @(posedge clk) begin
    if (do_push) begin
      mem[wr_ptr_q] <= i_entry;
    end
  end

  ////////////////////
  // Pointers and occupancy
  always_ff @(posedge clk or negedge i_arst_n) begin
    if (!i_arst_n) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (do_push) begin
        wr_ptr_q <= (wr_ptr_q == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr_q + 1'b1;
      end
      if (do_pop) begin
        rd_ptr_q <= (rd_ptr_q == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr_q + 1'b1;
      end
      count_q <= count_q + CNT_W'(do_push) - CNT_W'(do_pop);
    end
  end

endmodule

/* fp_misc_unit.sv */
// Sign injection, min/max, compares and class mask with req/ack result output
`timescale 1ns/1ps

module fp_misc_unit (
  input  logic                        clk,
  input  logic                        i_arst_n,
  input  logic                        i_empty,
  input  fp_misc_pkg::fp_classified_t i_head,
  input  logic                        i_ack,
  output logic                        o_pop,
  output logic                        o_req,
  output fp_misc_pkg::fp_result_t     o_result
);
  import fp_misc_pkg::*;

  fp_word_u                rs1;
  fp_word_u                rs2;
  fp_class_t               c1;
  fp_class_t               c2;
  logic                    nan1;
  logic                    nan2;
  logic                    snan_any;
  logic                    bits_eq;
  logic                    both_zero;
  logic                    lt_total;
  logic                    lt;
  logic                    eq;
  logic [CLASS_MASK_W-1:0] class_mask;
  fp_result_t              res_d;
  fp_result_t              res_q;
  logic                    req_q;

  assign rs1 = i_head.req.rs1;
  assign rs2 = i_head.req.rs2;
  assign c1  = i_head.cls1;
  assign c2  = i_head.cls2;

  assign nan1      = c1.is_snan | c1.is_qnan;
  assign nan2      = c2.is_snan | c2.is_qnan;
  assign snan_any  = c1.is_snan | c2.is_snan;
  assign bits_eq   = rs1.bits == rs2.bits;
  assign both_zero = c1.is_zero & c2.is_zero;

  ////////////////////
  // Ordering from signs and magnitude order
  // Total order for min/max puts -0 below +0
  assign lt_total = (rs1.f.sign != rs2.f.sign) ? rs1.f.sign :
                    rs1.f.sign ? (~i_head.mag_lt & ~bits_eq) : i_head.mag_lt;
  assign lt       = lt_total & ~both_zero;
  assign eq       = bits_eq | both_zero;

  // One-hot class, RISC-V bit order
  assign class_mask = {
    c1.is_qnan,
    c1.is_snan,
    ~rs1.f.sign & c1.is_inf,
    ~rs1.f.sign & ~c1.is_inf & ~nan1 & ~c1.is_zero & ~c1.is_subnormal,
    ~rs1.f.sign & c1.is_subnormal,
    ~rs1.f.sign & c1.is_zero,
    rs1.f.sign & c1.is_zero,
    rs1.f.sign & c1.is_subnormal,
    rs1.f.sign & ~c1.is_inf & ~nan1 & ~c1.is_zero & ~c1.is_subnormal,
    rs1.f.sign & c1.is_inf
  };

  ////////////////////
  // Result select
  always_comb begin
    res_d.value   = '0;
    res_d.invalid = 1'b0;
    case (i_head.req.op)
      FSGNJ:  res_d.value = {rs2.f.sign, rs1.bits[FLEN-2:0]};
      FSGNJN: res_d.value = {~rs2.f.sign, rs1.bits[FLEN-2:0]};
      FSGNJX: res_d.value = {rs1.f.sign ^ rs2.f.sign, rs1.bits[FLEN-2:0]};
      FMIN, FMAX: begin
        if (nan1 && nan2) begin
          res_d.value = CANONICAL_NAN;
        end else if (nan1) begin
          res_d.value = rs2.bits;
        end else if (nan2) begin
          res_d.value = rs1.bits;
        end else if (i_head.req.op == FMIN) begin
          res_d.value = lt_total ? rs1.bits : rs2.bits;
        end else begin
          res_d.value = lt_total ? rs2.bits : rs1.bits;
        end
        res_d.invalid = snan_any;
      end
      FEQ: begin
        res_d.value[0] = ~nan1 & ~nan2 & eq;
        res_d.invalid  = snan_any;
      end
      FLT: begin
        res_d.value[0] = ~nan1 & ~nan2 & lt;
        res_d.invalid  = nan1 | nan2;
      end
      FLE: begin
        res_d.value[0] = ~nan1 & ~nan2 & (lt | eq);
        res_d.invalid  = nan1 | nan2;
      end
      FCLASS: res_d.value = {{(FLEN - CLASS_MASK_W){1'b0}}, class_mask};
      default: res_d.value = '0;
    endcase
  end

  ////////////////////
  // Output four-phase handshake
  // Next pop waits for ack low after the previous result
  assign o_pop = ~req_q & ~i_ack & ~i_empty;

  always_ff @(posedge clk or negedge i_arst_n) begin
    if (!i_arst_n) begin
      req_q <= 1'b0;
    end else if (req_q && i_ack) begin
      req_q <= 1'b0;
    end else if (o_pop) begin
      req_q <= 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (o_pop) begin
      res_q <= res_d;
    end
  end

  assign o_req    = req_q;
  assign o_result = res_q;

endmodule

/* fp_misc_top.sv */
// Top level joining classifier, request FIFO and misc operation unit
`timescale 1ns/1ps

module fp_misc_top #(
  parameter int FIFO_DEPTH = 4
) (
  input  logic                     clk,
  input  logic                     i_arst_n,
  input  logic                     i_req,
  input  fp_misc_pkg::fp_request_t i_request,
  input  logic                     i_ack,
  output logic                     o_ack,
  output logic                     o_req,
  output fp_misc_pkg::fp_result_t  o_result
);
  import fp_misc_pkg::*;

  logic           push;
  logic           pop;
  logic           full;
  logic           empty;
  fp_classified_t entry;
  fp_classified_t head;

  fp_operand_classifier u_classifier (
    .clk       (clk),
    .i_arst_n  (i_arst_n),
    .i_req     (i_req),
    .i_request (i_request),
    .i_full    (full),
    .o_ack     (o_ack),
    .o_push    (push),
    .o_entry   (entry)
  );

  fp_request_fifo #(.DEPTH(FIFO_DEPTH)) u_fifo (
    .clk      (clk),
    .i_arst_n (i_arst_n),
    .i_push   (push),
    .i_entry  (entry),
    .i_pop    (pop),
    .o_full   (full),
    .o_empty  (empty),
    .o_head   (head)
  );

  fp_misc_unit u_misc_unit (
    .clk      (clk),
    .i_arst_n (i_arst_n),
    .i_empty  (empty),
    .i_head   (head),
    .i_ack    (i_ack),
    .o_pop    (pop),
    .o_req    (o_req),
    .o_result (o_result)
  );

endmodule

/* tb_fp_misc_tasks.svh */
// Reference model, four-phase driver and receiver, compare tasks and directed tests

////////////////////
// Error exit
task automatic fail_now(input string what);
  $display("%s", what);
  $display("Simulation failed");
  $fatal(1);
endtask

task automatic check_result(input string name, input fp_result_t got, input fp_result_t exp);
  if (got !== exp) begin
    $display("FAILED %s: value %h invalid %h, expected value %h invalid %h",
             name, got.value, got.invalid, exp.value, exp.invalid);
    fail_now("result mismatch");
  end
endtask

task automatic check_bit(input string name, input logic got, input logic exp);
  if (got !== exp) begin
    $display("FAILED %s: got %h expected %h", name, got, exp);
    fail_now("control bit mismatch");
  end
endtask

////////////////////
// Expected results from the operation rules
// Key that orders floats as unsigned words with -0 below +0
function automatic logic [31:0] order_key(input logic [31:0] x);
  return x[31] ? ~x : {1'b1, x[30:0]};
endfunction

function automatic fp_result_t expected_result(input fp_op_e op, input logic [31:0] a,
                                               input logic [31:0] b);
  fp_result_t r;
  logic       na;
  logic       nb;
  logic       sa;
  logic       sb;
  logic       zeros;
  logic       a_below;
  na      = (a[30:23] == 8'hFF) && (a[22:0] != 23'h0);
  nb      = (b[30:23] == 8'hFF) && (b[22:0] != 23'h0);
  sa      = na && !a[22];
  sb      = nb && !b[22];
  zeros   = (a[30:0] == 31'h0) && (b[30:0] == 31'h0);
  a_below = order_key(a) < order_key(b);
  r       = '0;
  case (op)
    FSGNJ:  r.value = {b[31], a[30:0]};
    FSGNJN: r.value = {~b[31], a[30:0]};
    FSGNJX: r.value = {a[31] ^ b[31], a[30:0]};
    FMIN, FMAX: begin
      if (na && nb) r.value = CANONICAL_NAN;
      else if (na) r.value = b;
      else if (nb) r.value = a;
      else r.value = ((op == FMIN) == a_below) ? a : b;
      r.invalid = sa || sb;
    end
    FEQ: begin
      r.value[0] = !na && !nb && ((a == b) || zeros);
      r.invalid  = sa || sb;
    end
    FLT: begin
      r.value[0] = !na && !nb && a_below && !zeros;
      r.invalid  = na || nb;
    end
    FLE: begin
      r.value[0] = !na && !nb && (a_below || (a == b) || zeros);
      r.invalid  = na || nb;
    end
    default: r = '0;
  endcase
  return r;
endfunction

////////////////////
// Four-phase driver and receiver
function automatic fp_request_t make_request(input fp_op_e op, input logic [31:0] a,
                                             input logic [31:0] b);
  fp_request_t r;
  r.op       = op;
  r.rs1.bits = a;
  r.rs2.bits = b;
  return r;
endfunction

task automatic send_request(input fp_request_t r);
  int n;
  i_request = r;
  i_req     = 1'b1;
  n         = 0;
  while (o_ack !== 1'b1) begin
    @(negedge clk);
    n++;
    if (n > TIMEOUT) fail_now("timeout waiting for o_ack to rise");
  end
  i_req = 1'b0;
  n     = 0;
  while (o_ack !== 1'b0) begin
    @(negedge clk);
    n++;
    if (n > TIMEOUT) fail_now("timeout waiting for o_ack to fall");
  end
endtask

task automatic get_result(output fp_result_t res);
  int n;
  n = 0;
  while (o_req !== 1'b1) begin
    @(negedge clk);
    n++;
    if (n > TIMEOUT) fail_now("timeout waiting for o_req to rise");
  end
  res   = o_result;
  i_ack = 1'b1;
  n     = 0;
  while (o_req !== 1'b0) begin
    @(negedge clk);
    n++;
    if (n > TIMEOUT) fail_now("timeout waiting for o_req to fall");
  end
  i_ack = 1'b0;
endtask

task automatic run_one_op(input fp_op_e op, input logic [31:0] a, input logic [31:0] b);
  fp_result_t got;
  send_request(make_request(op, a, b));
  get_result(got);
  check_result($sformatf("o_result (%s)", op.name()), got, expected_result(op, a, b));
endtask

////////////////////
// Directed tests
task automatic verify_reset();
  repeat (6) begin
    check_bit("o_ack", o_ack, 1'b0);
    check_bit("o_req", o_req, 1'b0);
    @(negedge clk);
  end
endtask

task automatic sign_injection_cases();
  logic [31:0] a;
  logic [31:0] b;
  repeat (8) begin
    a = $urandom();
    b = $urandom();
    run_one_op(FSGNJ, a, b);
    run_one_op(FSGNJN, a, b);
    run_one_op(FSGNJX, a, b);
  end
endtask

task automatic class_mask_cases();
  logic [31:0] vals [10];
  fp_result_t  got;
  fp_result_t  exp;
  // -inf, -normal, -subnormal, -0, +0, +subnormal, +normal, +inf, sNaN, qNaN
  vals = '{32'hFF80_0000, 32'hBF80_0000, 32'h8000_0001, 32'h8000_0000, 32'h0000_0000,
           32'h007F_FFFF, 32'h3F80_0000, 32'h7F80_0000, 32'h7F80_0001, 32'h7FC0_0000};
  for (int i = 0; i < 10; i++) begin
    send_request(make_request(FCLASS, vals[i], 32'h0));
    get_result(got);
    exp.value   = 32'h1 << i;
    exp.invalid = 1'b0;
    check_result("o_result (FCLASS)", got, exp);
  end
endtask

// Ordered pairs, equal pair, signed zeros, quiet and signalling NaN
task automatic sweep_pairs(input fp_op_e op);
  logic [31:0] pa [12];
  logic [31:0] pb [12];
  pa = '{32'h3F80_0000, 32'h4000_0000, 32'hBF80_0000, 32'hC000_0000, 32'h3F80_0000,
         32'h0000_0000, 32'h8000_0000, 32'h7FC0_0000, 32'h4000_0000, 32'h7F80_0001,
         32'h7FE0_0000, 32'h0000_0001};
  pb = '{32'h4000_0000, 32'h3F80_0000, 32'h3F80_0000, 32'hBF80_0000, 32'h3F80_0000,
         32'h8000_0000, 32'h0000_0000, 32'h4000_0000, 32'hFFC0_0000, 32'h3F80_0000,
         32'h7F80_0001, 32'h7F80_0000};
  for (int i = 0; i < 12; i++) begin
    run_one_op(op, pa[i], pb[i]);
  end
endtask

task automatic compare_cases();
  sweep_pairs(FEQ);
  sweep_pairs(FLT);
  sweep_pairs(FLE);
endtask

task automatic min_max_cases();
  sweep_pairs(FMIN);
  sweep_pairs(FMAX);
endtask

task automatic back_pressure_order();
  fp_result_t  expected [$];
  fp_result_t  got;
  fp_request_t r;
  fp_op_e      op;
  logic [31:0] a;
  logic [31:0] b;
  // FIFO_DEPTH entries plus one held result fill the path
  for (int i = 0; i <= FIFO_DEPTH; i++) begin
    op = fp_op_e'(i % 3);
    a  = $urandom();
    b  = $urandom();
    expected.push_back(expected_result(op, a, b));
    send_request(make_request(op, a, b));
  end
  a = $urandom();
  b = $urandom();
  r = make_request(FSGNJX, a, b);
  expected.push_back(expected_result(FSGNJX, a, b));
  i_request = r;
  i_req     = 1'b1;
  repeat (16) begin
    @(negedge clk);
    check_bit("o_ack", o_ack, 1'b0);
  end
  // Draining one result frees a slot for the waiting request
  get_result(got);
  check_result("o_result", got, expected.pop_front());
  send_request(r);
  while (expected.size() > 0) begin
    get_result(got);
    check_result("o_result", got, expected.pop_front());
  end
endtask

/* tb_fp_misc_top.sv */
// Testbench top with clock, reset, DUT instance and directed test sequence
`timescale 1ns/1ps

module tb_fp_misc_top;
  import fp_misc_pkg::*;

  localparam int FIFO_DEPTH = 4;
  localparam int TIMEOUT    = 200;

  logic        clk;
  logic        i_arst_n;
  logic        i_req;
  fp_request_t i_request;
  logic        i_ack;
  logic        o_ack;
  logic        o_req;
  fp_result_t  o_result;

  fp_misc_top #(.FIFO_DEPTH(FIFO_DEPTH)) u_fp_misc_top (
    .clk       (clk),
    .i_arst_n  (i_arst_n),
    .i_req     (i_req),
    .i_request (i_request),
    .i_ack     (i_ack),
    .o_ack     (o_ack),
    .o_req     (o_req),
    .o_result  (o_result)
  );

  `include "tb_fp_misc_tasks.svh"

  ////////////////////
  // 8 ns clock
  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  initial begin
    void'($urandom(95));
    i_arst_n  = 1'b0;
    i_req     = 1'b0;
    i_request = '0;
    i_ack     = 1'b0;
    // Reset held for three cycles and released on a falling edge
    repeat (3) @(posedge clk);
    @(negedge clk);
    i_arst_n = 1'b1;

    verify_reset();
    sign_injection_cases();
    class_mask_cases();
    compare_cases();
    min_max_cases();
    back_pressure_order();

    $display("Simulation completed successfully");
    $finish;
  end

endmodule

/* build.f */
+incdir+.
fp_misc_pkg.sv
fp_operand_classifier.sv
fp_request_fifo.sv
fp_misc_unit.sv
fp_misc_top.sv
tb_fp_misc_top.sv

/* Makefile */
VERILATOR ?= verilator
TOP       ?= tb_fp_misc_top
FILELIST  ?= build.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --timing

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) --binary $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP)

clean:
	rm -rf $(OBJ_DIR)
